/* Bender.yml */
package:
  name: mips_cf

export_include_dirs:
  - include

sources:
  - rtl/mips_cf_pkg.sv
  - rtl/cf_stage_if.sv
  - rtl/cf_decode.sv
  - rtl/cf_execute.sv
  - rtl/cf_result.sv
  - rtl/mips_cf_top.sv
  - target: simulation
    files:
      - sim/tb_mips_cf.sv

/* include/mips_cf_cfg.svh */
`ifndef MIPS_CF_CFG_SVH
`define MIPS_CF_CFG_SVH

// address of the first instruction fetched after reset.
`define CF_RESET_PC 32'h0000_0000

// register written with the return address by jal, bgezal and bltzal.
// jalr names its own destination in rd instead.
`define CF_LINK_REG 5'd31

`endif

/* rtl/cf_decode.sv */
`timescale 1ns/100ps
`include "mips_cf_cfg.svh"

module cf_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  mips_cf_pkg::word_t instr,
    input  mips_cf_pkg::word_t rs_val,
    input  mips_cf_pkg::word_t rt_val,
    output logic               instr_ready,
    cf_dec_if.dec              dec
);
    import mips_cf_pkg::*;

    dec_state_t state;
    opcode_t    opcode;
    funct_t     funct;
    reg_idx_t   rt_field;
    reg_idx_t   rd_field;
    cf_kind_t   kind_in;
    reg_idx_t   link_in;
    logic       accept;

    assign opcode   = instr[31:26];
    assign rt_field = instr[20:16];
    assign rd_field = instr[15:11];
    assign funct    = instr[5:0];

    // one instruction in flight, so ready simply means we are in accept.
    assign instr_ready = (state == DEC_ACCEPT);
    assign accept      = instr_valid && instr_ready;
    assign dec.valid   = (state == DEC_COMMIT);

    always_comb begin
        kind_in = CF_NONE;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    kind_in = CF_JR;
                end else if (funct == FN_JALR) begin
                    kind_in = CF_JALR;
                end
            end
            OP_REGIMM: begin
                case (rt_field)
                    RT_BLTZ:   kind_in = CF_BLTZ;
                    RT_BGEZ:   kind_in = CF_BGEZ;
                    RT_BLTZAL: kind_in = CF_BLTZAL;
                    RT_BGEZAL: kind_in = CF_BGEZAL;
                    default:   kind_in = CF_NONE;
                endcase
            end
            OP_J:    kind_in = CF_J;
            OP_JAL:  kind_in = CF_JAL;
            OP_BEQ:  kind_in = CF_BEQ;
            OP_BNE:  kind_in = CF_BNE;
            OP_BLEZ: kind_in = CF_BLEZ;
            OP_BGTZ: kind_in = CF_BGTZ;
            default: kind_in = CF_NONE;
        endcase
    end

    // jalr is the only form that names its link register.
    assign link_in = (kind_in == CF_JALR) ? rd_field : `CF_LINK_REG;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DEC_ACCEPT;
        end else if (state == DEC_ACCEPT) begin
            if (accept) begin
                state <= DEC_COMMIT;
            end
        end else begin
            state <= DEC_ACCEPT;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.kind     <= kind_in;
            dec.rs_val   <= rs_val;
            dec.rt_val   <= rt_val;
            dec.imm      <= instr[15:0];
            dec.jidx     <= instr[25:0];
            dec.link_reg <= link_in;
        end
    end

endmodule

/* rtl/cf_execute.sv */
`timescale 1ns/100ps

module cf_execute (
    cf_dec_if.exe dec,
    cf_exe_if.exe exe
);
    import mips_cf_pkg::*;

    word_t              seq;
    word_t              br_target;
    word_t              j_target;
    logic signed [31:0] rs_s;
    logic               rs_neg;
    logic               rs_zero;
    logic               taken;

    // no delay slot, so the fall-through address is also the return address.
    assign seq       = exe.cur_pc + 32'd4;
    assign br_target = seq + {{14{dec.imm[15]}}, dec.imm, 2'b00};
    assign j_target  = {seq[31:28], dec.jidx, 2'b00};

    assign rs_s    = dec.rs_val;
    assign rs_neg  = (rs_s < 0);
    assign rs_zero = (rs_s == 0);

    always_comb begin
        case (dec.kind)
            CF_BEQ:              taken = (dec.rs_val == dec.rt_val);
            CF_BNE:              taken = (dec.rs_val != dec.rt_val);
            CF_BGEZ, CF_BGEZAL:  taken = !rs_neg;
            CF_BGTZ:             taken = !rs_neg && !rs_zero;
            CF_BLEZ:             taken = rs_neg || rs_zero;
            CF_BLTZ, CF_BLTZAL:  taken = rs_neg;
            default:             taken = 1'b0;
        endcase
    end

    // anything that is not a jump falls back on the branch decision.
    always_comb begin
        case (dec.kind)
            CF_J, CF_JAL: begin
                exe.next_pc = j_target;
            end
            CF_JR, CF_JALR: begin
                exe.next_pc = dec.rs_val;
            end
            default: begin
                exe.next_pc = taken ? br_target : seq;
            end
        endcase
    end

    // linking branches write the return address even when not taken.
    assign exe.link = (dec.kind == CF_JAL) || (dec.kind == CF_JALR) ||
                      (dec.kind == CF_BGEZAL) || (dec.kind == CF_BLTZAL);

    assign exe.link_data = seq;
    assign exe.valid     = dec.valid;

endmodule

/* rtl/cf_result.sv */
`timescale 1ns/100ps
`include "mips_cf_cfg.svh"

module cf_result (
    input  logic                   clk,
    input  logic                   rst_n,
    cf_dec_if.exe                  dec,
    cf_exe_if.res                  exe,
    output mips_cf_pkg::word_t     pc,
    output logic                   link_valid,
    output mips_cf_pkg::reg_idx_t  link_reg,
    output mips_cf_pkg::word_t     link_data
);

    // the committed pc is also the base for the instruction now in execute.
    assign exe.cur_pc = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CF_RESET_PC;
        end else if (exe.valid) begin
            pc <= exe.next_pc;
        end
    end

    // valid is only ever high for one cycle, which makes this a strobe.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_valid <= 1'b0;
        end else begin
            link_valid <= exe.valid && exe.link;
        end
    end

    always_ff @(posedge clk) begin
        if (exe.valid && exe.link) begin
            link_reg  <= dec.link_reg;
            link_data <= exe.link_data;
        end
    end

endmodule

/* rtl/cf_stage_if.sv */
`timescale 1ns/100ps

// decoded instruction, held by decode while it waits to commit.
interface cf_dec_if;
    import mips_cf_pkg::*;

    logic     valid;
    cf_kind_t kind;
    word_t    rs_val;
    word_t    rt_val;
    imm16_t   imm;
    jidx_t    jidx;
    reg_idx_t link_reg;

    modport dec (output valid, kind, rs_val, rt_val, imm, jidx, link_reg);
    modport exe (input valid, kind, rs_val, rt_val, imm, jidx, link_reg);
endinterface

// next pc and link data towards result, current pc back to execute.
interface cf_exe_if;
    import mips_cf_pkg::*;

    logic  valid;
    word_t next_pc;
    logic  link;
    word_t link_data;
    word_t cur_pc;

    modport exe (output valid, next_pc, link, link_data, input cur_pc);
    modport res (input valid, next_pc, link, link_data, output cur_pc);
endinterface

/* rtl/mips_cf_pkg.sv */
package mips_cf_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jidx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes, instr[31:26].
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;

    // funct codes under OP_SPECIAL, instr[5:0].
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;

    // regimm branches are selected by the rt field, instr[20:16].
    localparam reg_idx_t RT_BLTZ   = 5'h00;
    localparam reg_idx_t RT_BGEZ   = 5'h01;
    localparam reg_idx_t RT_BLTZAL = 5'h10;
    localparam reg_idx_t RT_BGEZAL = 5'h11;

    typedef enum logic [3:0] {
        CF_NONE,
        CF_J,
        CF_JAL,
        CF_JR,
        CF_JALR,
        CF_BEQ,
        CF_BNE,
        CF_BGEZ,
        CF_BGEZAL,
        CF_BGTZ,
        CF_BLEZ,
        CF_BLTZ,
        CF_BLTZAL
    } cf_kind_t;

    typedef enum logic {
        DEC_ACCEPT,
        DEC_COMMIT
    } dec_state_t;

endpackage

/* rtl/mips_cf_top.sv */
`timescale 1ns/100ps

module mips_cf_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // instruction side, one word per handshake.
    input  logic                  instr_valid,
    input  mips_cf_pkg::word_t    instr,
    input  mips_cf_pkg::word_t    rs_val,
    input  mips_cf_pkg::word_t    rt_val,
    output logic                  instr_ready,

    // address of the next instruction to present.
    output mips_cf_pkg::word_t    pc,

    // register write request for the linking forms.
    output logic                  link_valid,
    output mips_cf_pkg::reg_idx_t link_reg,
    output mips_cf_pkg::word_t    link_data
);

    cf_dec_if dec_if ();
    cf_exe_if exe_if ();

    cf_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .instr_ready (instr_ready),
        .dec         (dec_if.dec)
    );

    cf_execute u_execute (
        .dec (dec_if.exe),
        .exe (exe_if.exe)
    );

    // result takes link_reg straight from decode, alongside the execute result.
    cf_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec_if.exe),
        .exe        (exe_if.res),
        .pc         (pc),
        .link_valid (link_valid),
        .link_reg   (link_reg),
        .link_data  (link_data)
    );

endmodule

/* sim/tb_mips_cf.sv */
`timescale 1ns/100ps
`include "mips_cf_cfg.svh"

module tb_mips_cf;
    import mips_cf_pkg::*;

    localparam int N_SEQ  = 4;
    localparam int N_EQ   = 16;
    localparam int N_SIGN = 32;
    localparam int N_JUMP = 4;
    localparam int N_LINK = 6;
    localparam int TIMEOUT_CYCLES = 2 * (N_SEQ + N_EQ + N_SIGN + N_JUMP + N_LINK) * 2 + 100;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    word_t    instr;
    word_t    rs_val;
    word_t    rt_val;
    logic     instr_ready;
    word_t    pc;
    logic     link_valid;
    reg_idx_t link_reg;
    word_t    link_data;

    word_t model_pc;
    word_t lcg_state;
    int    checks;
    int    errors;
    int    cycles;

    mips_cf_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .instr_ready (instr_ready),
        .pc          (pc),
        .link_valid  (link_valid),
        .link_reg    (link_reg),
        .link_data   (link_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(opcode_t op, jidx_t idx);
        return {op, idx};
    endfunction

    function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    // taken branches land at the fall-through address plus the offset in words.
    function automatic word_t branch_next(logic taken, imm16_t off);
        word_t ext;
        ext = {{16{off[15]}}, off};
        return taken ? (model_pc + 32'd4 + (ext << 2)) : (model_pc + 32'd4);
    endfunction

    function automatic word_t jump_target(jidx_t idx);
        word_t seq;
        seq = model_pc + 32'd4;
        return {seq[31:28], idx, 2'b00};
    endfunction

    task automatic check_word(word_t actual, word_t expected, string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_reg(reg_idx_t actual, reg_idx_t expected, string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic report_test(string name, int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // called on a falling edge; returns on the falling edge after acceptance.
    task automatic send_instr(word_t word, word_t rs, word_t rt);
        while (instr_ready !== 1'b1) begin
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr       = word;
        rs_val      = rs;
        rt_val      = rt;
        @(negedge clk);
        instr_valid = 1'b0;
        check_flag(instr_ready, 1'b0, "instr_ready after acceptance");
        check_flag(link_valid, 1'b0, "link_valid before commit");
    endtask

    task automatic commit_check(word_t exp_pc, logic exp_link, reg_idx_t exp_reg);
        @(negedge clk);
        check_word(pc, exp_pc, "pc");
        check_flag(link_valid, exp_link, "link_valid");
        if (exp_link) begin
            check_reg(link_reg, exp_reg, "link_reg");
            check_word(link_data, model_pc + 32'd4, "link_data");
        end
        check_flag(instr_ready, 1'b1, "instr_ready after commit");
        model_pc = exp_pc;
    endtask

    task automatic exec_instr(word_t word, word_t rs, word_t rt, word_t exp_pc,
                              logic exp_link, reg_idx_t exp_reg);
        send_instr(word, rs, rt);
        commit_check(exp_pc, exp_link, exp_reg);
    endtask

    task automatic test_sequential();
        int    err0;
        word_t words [N_SEQ];
        err0 = errors;
        check_word(pc, `CF_RESET_PC, "pc after reset");
        check_flag(instr_ready, 1'b1, "instr_ready after reset");
        check_flag(link_valid, 1'b0, "link_valid after reset");
        model_pc = `CF_RESET_PC;
        // addiu, add, a regimm word with an unused rt code, and lw.
        words[0] = enc_i(6'h09, 5'd1, 5'd2, 16'h1234);
        words[1] = enc_r(5'd1, 5'd2, 5'd3, 6'h20);
        words[2] = enc_i(OP_REGIMM, 5'd4, 5'h02, 16'h0010);
        words[3] = enc_i(6'h23, 5'd5, 5'd6, 16'h0008);
        for (int i = 0; i < N_SEQ; i++) begin
            exec_instr(words[i], lcg_next(), lcg_next(), model_pc + 32'd4, 1'b0, 5'd0);
        end
        report_test("sequential", err0);
    endtask

    task automatic test_beq_bne();
        int     err0;
        word_t  a;
        word_t  b;
        word_t  r;
        imm16_t off;
        err0 = errors;
        for (int i = 0; i < N_EQ / 2; i++) begin
            a = lcg_next();
            b = (i % 2 == 0) ? a : lcg_next();
            r = lcg_next();
            off = r[22:7];
            if (i % 3 == 1) begin
                off[15] = 1'b1;
            end
            exec_instr(enc_i(OP_BEQ, 5'd8, 5'd9, off), a, b, branch_next(a == b, off),
                       1'b0, 5'd0);
            exec_instr(enc_i(OP_BNE, 5'd8, 5'd9, off), a, b, branch_next(a != b, off),
                       1'b0, 5'd0);
        end
        report_test("beq_bne", err0);
    endtask

    task automatic test_sign_branches();
        int                 err0;
        word_t              vals [8];
        word_t              r;
        imm16_t             off;
        logic signed [31:0] v;
        err0 = errors;
        vals[0] = 32'h0000_0000;
        vals[1] = 32'h8000_0000;
        vals[2] = 32'h0000_0001;
        vals[3] = 32'hffff_ffff;
        vals[4] = 32'h7fff_ffff;
        for (int i = 5; i < 8; i++) begin
            vals[i] = lcg_next();
        end
        for (int i = 0; i < 8; i++) begin
            v = vals[i];
            r = lcg_next();
            off = r[17:2];
            exec_instr(enc_i(OP_REGIMM, 5'd10, RT_BGEZ, off), vals[i], lcg_next(),
                       branch_next(v >= 0, off), 1'b0, 5'd0);
            exec_instr(enc_i(OP_BGTZ, 5'd10, 5'd0, off), vals[i], lcg_next(),
                       branch_next(v > 0, off), 1'b0, 5'd0);
            exec_instr(enc_i(OP_BLEZ, 5'd10, 5'd0, off), vals[i], lcg_next(),
                       branch_next(v <= 0, off), 1'b0, 5'd0);
            exec_instr(enc_i(OP_REGIMM, 5'd10, RT_BLTZ, off), vals[i], lcg_next(),
                       branch_next(v < 0, off), 1'b0, 5'd0);
        end
        report_test("sign_branches", err0);
    endtask

    task automatic test_jumps();
        int    err0;
        word_t r;
        jidx_t idx;
        err0 = errors;
        // jr into a high region first, so j has upper bits to keep.
        exec_instr(enc_r(5'd5, 5'd0, 5'd0, FN_JR), 32'ha000_1000, lcg_next(), 32'ha000_1000,
                   1'b0, 5'd0);
        r = lcg_next();
        idx = r[25:0];
        exec_instr(enc_j(OP_J, idx), lcg_next(), lcg_next(), jump_target(idx), 1'b0, 5'd0);
        r = lcg_next();
        r[1:0] = 2'b00;
        exec_instr(enc_r(5'd5, 5'd0, 5'd0, FN_JR), r, lcg_next(), r, 1'b0, 5'd0);
        r = lcg_next();
        idx = r[25:0];
        exec_instr(enc_j(OP_J, idx), lcg_next(), lcg_next(), jump_target(idx), 1'b0, 5'd0);
        report_test("jumps", err0);
    endtask

    task automatic test_links();
        int       err0;
        word_t    r;
        jidx_t    idx;
        imm16_t   off;
        reg_idx_t rd;
        err0 = errors;
        r = lcg_next();
        idx = r[25:0];
        exec_instr(enc_j(OP_JAL, idx), lcg_next(), lcg_next(), jump_target(idx), 1'b1,
                   `CF_LINK_REG);
        rd = 5'd12;
        r = lcg_next();
        r[1:0] = 2'b00;
        exec_instr(enc_r(5'd6, 5'd0, rd, FN_JALR), r, lcg_next(), r, 1'b1, rd);
        off = 16'hfff0;
        exec_instr(enc_i(OP_REGIMM, 5'd7, RT_BGEZAL, off), 32'd5, lcg_next(),
                   branch_next(1'b1, off), 1'b1, `CF_LINK_REG);
        exec_instr(enc_i(OP_REGIMM, 5'd7, RT_BGEZAL, off), 32'hffff_fff0, lcg_next(),
                   branch_next(1'b0, off), 1'b1, `CF_LINK_REG);
        off = 16'h0020;
        exec_instr(enc_i(OP_REGIMM, 5'd7, RT_BLTZAL, off), 32'h8000_0000, lcg_next(),
                   branch_next(1'b1, off), 1'b1, `CF_LINK_REG);
        exec_instr(enc_i(OP_REGIMM, 5'd7, RT_BLTZAL, off), 32'd0, lcg_next(),
                   branch_next(1'b0, off), 1'b1, `CF_LINK_REG);
        report_test("links", err0);
    endtask

    task automatic test_idle();
        int err0;
        err0 = errors;
        // a jal word on the bus must be ignored while instr_valid is low.
        instr  = enc_j(OP_JAL, 26'h123_4567);
        rs_val = lcg_next();
        rt_val = lcg_next();
        repeat (5) begin
            @(negedge clk);
            check_word(pc, model_pc, "pc while idle");
            check_flag(link_valid, 1'b0, "link_valid while idle");
            check_flag(instr_ready, 1'b1, "instr_ready while idle");
        end
        report_test("idle", err0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rs_val      = '0;
        rt_val      = '0;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        lcg_state   = 32'h77c0c15a;
        model_pc    = `CF_RESET_PC;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        test_sequential();
        test_beq_bne();
        test_sign_branches();
        test_jumps();
        test_links();
        test_idle();
        $display("all tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
rtl/mips_cf_pkg.sv
rtl/cf_stage_if.sv
rtl/cf_decode.sv
rtl/cf_execute.sv
rtl/cf_result.sv
rtl/mips_cf_top.sv
sim/tb_mips_cf.sv
